/* design/rv_ctl_pkg.sv */
package rv_ctl_pkg;

    // RV32I field widths
    localparam int INSTR_W     = 32;
    localparam int OPCODE_W    = 7;
    localparam int FUNCT3_W    = 3;
    localparam int FUNCT7_W    = 7;
    localparam int ALU_OP_W    = 4;
    localparam int IMM_FMT_W   = 3;
    localparam int WB_SEL_W    = 2;
    localparam int ALU_CLASS_W = 2;

    typedef logic [INSTR_W-1:0]  instr_t;
    typedef logic [FUNCT3_W-1:0] funct3_t;

    // funct7 patterns of the base ISA
    localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'b0100000;

    typedef enum logic [OPCODE_W-1:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Codes follow the datapath ALU encoding
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_ADD    = 4'b0010,
        ALU_SUB    = 4'b0011,
        ALU_SLT    = 4'b0100,
        ALU_PASS_B = 4'b0101,
        ALU_SLTU   = 4'b0110,
        ALU_SLL    = 4'b1000,
        ALU_XOR    = 4'b1001,
        ALU_SRL    = 4'b1100,
        ALU_SRA    = 4'b1101
    } alu_op_e;

    typedef enum logic [IMM_FMT_W-1:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    typedef enum logic [WB_SEL_W-1:0] {
        WB_MEM      = 2'd0,
        WB_ALU      = 2'd1,
        WB_PC_PLUS4 = 2'd2
    } wb_sel_e;

    // How the ALU operation is chosen
    typedef enum logic [ALU_CLASS_W-1:0] {
        CLS_ADD_ONLY = 2'd0,
        CLS_PASS     = 2'd1,
        CLS_IMM      = 2'd2,
        CLS_REG      = 2'd3
    } alu_class_e;

endpackage

/* design/main_decoder.sv */
`timescale 1ns/100ps

module main_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  rv_ctl_pkg::instr_t     instruction,
    output logic                   is_branch,
    output logic                   is_jump,
    output rv_ctl_pkg::alu_class_e alu_class,
    output logic                   alu_alt,
    output logic                   out_valid,
    output logic                   illegal,
    output logic                   a_sel,
    output logic                   b_sel,
    output rv_ctl_pkg::imm_fmt_e   imm_sel,
    output logic                   reg_wen,
    output logic                   mem_wr,
    output rv_ctl_pkg::wb_sel_e    wb_sel
);
    import rv_ctl_pkg::*;

    opcode_e              opcode;
    funct3_t              funct3;
    logic [FUNCT7_W-1:0]  funct7;
    logic                 legal;
    logic                 accept;
    logic                 a_sel_d;
    logic                 b_sel_d;
    imm_fmt_e             imm_sel_d;
    wb_sel_e              wb_sel_d;
    logic                 reg_wen_d;
    logic                 mem_wr_d;

    assign opcode = opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // Legality of the kept RV32I subset
    always_comb begin
        legal = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL: legal = 1'b1;
            OPC_JALR:   legal = (funct3 == 3'b000);
            // funct3 010 and 011 are reserved
            OPC_BRANCH: legal = (funct3[2:1] != 2'b01);
            OPC_LOAD:   legal = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
            OPC_STORE:  legal = !funct3[2] && (funct3 != 3'b011);
            OPC_OP_IMM: begin
                case (funct3)
                    3'b001:  legal = (funct7 == FUNCT7_BASE);
                    3'b101:  legal = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
                    default: legal = 1'b1;
                endcase
            end
            OPC_OP: begin
                legal = (funct7 == FUNCT7_BASE) ||
                        ((funct7 == FUNCT7_ALT) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
            end
            default: legal = 1'b0;
        endcase
    end

    assign accept = in_valid && legal;

    // Datapath selects per opcode
    always_comb begin
        a_sel_d   = 1'b0;
        b_sel_d   = 1'b1;
        imm_sel_d = IMM_NONE;
        wb_sel_d  = WB_ALU;
        reg_wen_d = 1'b0;
        mem_wr_d  = 1'b0;
        alu_class = CLS_ADD_ONLY;
        case (opcode)
            OPC_LUI: begin
                imm_sel_d = IMM_U;
                reg_wen_d = 1'b1;
                alu_class = CLS_PASS;
            end
            OPC_AUIPC: begin
                a_sel_d   = 1'b1;
                imm_sel_d = IMM_U;
                reg_wen_d = 1'b1;
            end
            OPC_JAL: begin
                a_sel_d   = 1'b1;
                imm_sel_d = IMM_J;
                wb_sel_d  = WB_PC_PLUS4;
                reg_wen_d = 1'b1;
            end
            OPC_JALR: begin
                imm_sel_d = IMM_I;
                wb_sel_d  = WB_PC_PLUS4;
                reg_wen_d = 1'b1;
            end
            OPC_BRANCH: begin
                a_sel_d   = 1'b1;
                imm_sel_d = IMM_B;
            end
            OPC_LOAD: begin
                imm_sel_d = IMM_I;
                wb_sel_d  = WB_MEM;
                reg_wen_d = 1'b1;
            end
            OPC_STORE: begin
                imm_sel_d = IMM_S;
                mem_wr_d  = 1'b1;
            end
            OPC_OP_IMM: begin
                imm_sel_d = IMM_I;
                reg_wen_d = 1'b1;
                alu_class = CLS_IMM;
            end
            OPC_OP: begin
                b_sel_d   = 1'b0;
                reg_wen_d = 1'b1;
                alu_class = CLS_REG;
            end
            default: ;
        endcase
    end

    assign is_branch = accept && (opcode == OPC_BRANCH);
    assign is_jump   = accept && ((opcode == OPC_JAL) || (opcode == OPC_JALR));
    assign alu_alt   = legal && funct7[5];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            illegal   <= 1'b0;
            reg_wen   <= 1'b0;
            mem_wr    <= 1'b0;
        end else begin
            out_valid <= in_valid;
            illegal   <= in_valid && !legal;
            reg_wen   <= accept && reg_wen_d;
            mem_wr    <= accept && mem_wr_d;
        end
    end

    // Registered datapath selects
    always_ff @(posedge clk) begin
        a_sel   <= a_sel_d;
        b_sel   <= b_sel_d;
        imm_sel <= imm_sel_d;
        wb_sel  <= wb_sel_d;
    end

endmodule

/* design/alu_op_decoder.sv */
`timescale 1ns/100ps

module alu_op_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_ctl_pkg::alu_class_e alu_class,
    input  rv_ctl_pkg::funct3_t    funct3,
    input  logic                   alu_alt,
    output rv_ctl_pkg::alu_op_e    alu_sel
);
    import rv_ctl_pkg::*;

    alu_op_e op_d;
    logic    use_sub;

    // SUB exists only in the register form
    assign use_sub = alu_alt && (alu_class == CLS_REG);

    always_comb begin
        op_d = ALU_ADD;
        case (alu_class)
            CLS_PASS:     op_d = ALU_PASS_B;
            CLS_ADD_ONLY: op_d = ALU_ADD;
            CLS_IMM, CLS_REG: begin
                case (funct3)
                    3'b000: begin
                        if (use_sub) begin
                            op_d = ALU_SUB;
                        end else begin
                            op_d = ALU_ADD;
                        end
                    end
                    3'b001: op_d = ALU_SLL;
                    3'b010: op_d = ALU_SLT;
                    3'b011: op_d = ALU_SLTU;
                    3'b100: op_d = ALU_XOR;
                    3'b101: begin
                        // Arithmetic shift when funct7 bit 5 set
                        if (alu_alt) begin
                            op_d = ALU_SRA;
                        end else begin
                            op_d = ALU_SRL;
                        end
                    end
                    3'b110: op_d = ALU_OR;
                    default: op_d = ALU_AND;
                endcase
            end
            default: op_d = ALU_ADD;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_sel <= ALU_ADD;
        end else begin
            alu_sel <= op_d;
        end
    end

endmodule

/* design/branch_resolver.sv */
`timescale 1ns/100ps

module branch_resolver (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_ctl_pkg::funct3_t funct3,
    input  logic                is_branch,
    input  logic                is_jump,
    input  logic                br_eq,
    input  logic                br_lt,
    output logic                br_un,
    output logic                pc_sel
);
    import rv_ctl_pkg::*;

    logic taken;

    // Unsigned compare for BLTU and BGEU
    assign br_un = is_branch && funct3[2] && funct3[1];

    always_comb begin
        case (funct3)
            3'b000:        taken = br_eq;
            3'b001:        taken = !br_eq;
            3'b100, 3'b110: taken = br_lt;
            3'b101, 3'b111: taken = !br_lt;
            default:       taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_sel <= 1'b0;
        end else begin
            pc_sel <= is_jump || (is_branch && taken);
        end
    end

endmodule

/* design/instr_ctl.sv */
`timescale 1ns/100ps

module instr_ctl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  rv_ctl_pkg::instr_t   instruction,
    input  logic                 br_eq,
    input  logic                 br_lt,
    output logic                 out_valid,
    output logic                 illegal,
    output logic                 a_sel,
    output logic                 b_sel,
    output rv_ctl_pkg::alu_op_e  alu_sel,
    output rv_ctl_pkg::imm_fmt_e imm_sel,
    output logic                 reg_wen,
    output logic                 mem_wr,
    output rv_ctl_pkg::wb_sel_e  wb_sel,
    output logic                 br_un,
    output logic                 pc_sel
);
    import rv_ctl_pkg::*;

    logic       is_branch;
    logic       is_jump;
    alu_class_e alu_class;
    logic       alu_alt;

    main_decoder u_main_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .instruction (instruction),
        .is_branch   (is_branch),
        .is_jump     (is_jump),
        .alu_class   (alu_class),
        .alu_alt     (alu_alt),
        .out_valid   (out_valid),
        .illegal     (illegal),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .imm_sel     (imm_sel),
        .reg_wen     (reg_wen),
        .mem_wr      (mem_wr),
        .wb_sel      (wb_sel)
    );

    alu_op_decoder u_alu_op_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_class (alu_class),
        .funct3    (instruction[14:12]),
        .alu_alt   (alu_alt),
        .alu_sel   (alu_sel)
    );

    // Branch outcome from the comparator flags
    branch_resolver u_branch_resolver (
        .clk       (clk),
        .rst_n     (rst_n),
        .funct3    (instruction[14:12]),
        .is_branch (is_branch),
        .is_jump   (is_jump),
        .br_eq     (br_eq),
        .br_lt     (br_lt),
        .br_un     (br_un),
        .pc_sel    (pc_sel)
    );

endmodule

/* verification/instr_ctl_asserts.sv */
`timescale 1ns/100ps

module instr_ctl_asserts (
    input logic clk,
    input logic rst_n,
    input logic out_valid,
    input logic illegal,
    input logic reg_wen,
    input logic mem_wr,
    input logic pc_sel
);
    int fail_count = 0;

    // A result writes the register file or memory, never both
    single_write: assert property (
        @(posedge clk) disable iff (!rst_n) !(reg_wen && mem_wr)
    ) else begin
        fail_count = fail_count + 1;
        $error("reg_wen and mem_wr are high in the same cycle");
    end

    illegal_inert: assert property (
        @(posedge clk) disable iff (!rst_n) illegal |-> !reg_wen && !mem_wr && !pc_sel
    ) else begin
        fail_count = fail_count + 1;
        $error("illegal instruction wrote state or redirected the PC");
    end

    // Empty stage slot
    bubble_no_write: assert property (
        @(posedge clk) disable iff (!rst_n) !out_valid |-> !reg_wen && !mem_wr
    ) else begin
        fail_count = fail_count + 1;
        $error("write enable high while out_valid is low");
    end

endmodule

bind instr_ctl instr_ctl_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .illegal   (illegal),
    .reg_wen   (reg_wen),
    .mem_wr    (mem_wr),
    .pc_sel    (pc_sel)
);

/* verification/instr_ctl_tb.sv */
`timescale 1ns/100ps

module instr_ctl_tb;
    import rv_ctl_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 3;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          COMB_DELAY   = 20;
    localparam logic [31:0] LFSR_SEED    = 32'hb87b_bd1c;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam string       CASE_FILE    = "verification/instr_ctl_cases.txt";

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic        br_eq;
        logic        br_lt;
        logic        illegal;
        logic        a_sel;
        logic        b_sel;
        logic [3:0]  alu_sel;
        logic [2:0]  imm_sel;
        logic        reg_wen;
        logic        mem_wr;
        logic [1:0]  wb_sel;
        logic        br_un;
        logic        pc_sel;
    } case_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    instr_t      instruction;
    logic        br_eq;
    logic        br_lt;
    logic        out_valid;
    logic        illegal;
    logic        a_sel;
    logic        b_sel;
    alu_op_e     alu_sel;
    imm_fmt_e    imm_sel;
    logic        reg_wen;
    logic        mem_wr;
    wb_sel_e     wb_sel;
    logic        br_un;
    logic        pc_sel;

    case_t       cases[$];
    case_t       pending[$];
    logic [31:0] lfsr;
    int          cycles;
    int          limit;

    instr_ctl DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .out_valid   (out_valid),
        .illegal     (illegal),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .alu_sel     (alu_sel),
        .imm_sel     (imm_sel),
        .reg_wen     (reg_wen),
        .mem_wr      (mem_wr),
        .wb_sel      (wb_sel),
        .br_un       (br_un),
        .pc_sel      (pc_sel)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ LFSR_TAPS;
        end
        return shifted;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "output check failed");
        end
    endtask

    // Register, immediate and funct7 bits replaced by LFSR bits
    task automatic scramble_fields(input logic [31:0] tmpl, output logic [31:0] instr);
        logic [31:0] mask;
        logic [6:0]  opc;
        logic [2:0]  f3;
        opc  = tmpl[6:0];
        f3   = tmpl[14:12];
        mask = 32'h01ff_8f80;
        if (!((opc == OPC_OP) || ((opc == OPC_OP_IMM) && (f3 == 3'b001 || f3 == 3'b101)))) begin
            mask = mask | 32'hfe00_0000;
        end
        // funct3 is immediate in U and J formats
        if ((opc == OPC_LUI) || (opc == OPC_AUIPC) || (opc == OPC_JAL)) begin
            mask = mask | 32'h0000_7000;
        end
        instr = tmpl;
        for (int i = 0; i < 32; i++) begin
            if (mask[i]) begin
                instr[i] = lfsr[0];
                lfsr     = lfsr_next(lfsr);
            end
        end
    endtask

    task automatic read_cases();
        int          fd;
        int          got;
        string       line;
        logic [31:0] col [14];
        case_t       c;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the case file %s", CASE_FILE);
            $display("=== FAIL ===");
            $fatal(1, "no case file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                                  col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
                    if (got == 14) begin
                        c.valid   = col[0][0];
                        c.instr   = col[1];
                        c.br_eq   = col[2][0];
                        c.br_lt   = col[3][0];
                        c.illegal = col[4][0];
                        c.a_sel   = col[5][0];
                        c.b_sel   = col[6][0];
                        c.alu_sel = col[7][3:0];
                        c.imm_sel = col[8][2:0];
                        c.reg_wen = col[9][0];
                        c.mem_wr  = col[10][0];
                        c.wb_sel  = col[11][1:0];
                        c.br_un   = col[12][0];
                        c.pc_sel  = col[13][0];
                        cases.push_back(c);
                    end
                end
            end
            $fclose(fd);
            if (cases.size() == 0) begin
                $display("The case file %s holds no usable cases", CASE_FILE);
                $display("=== FAIL ===");
                $fatal(1, "no cases");
            end
        end
    endtask

    task automatic expect_idle();
        compare_value("out_valid", 32'(out_valid), 32'd0);
        compare_value("illegal", 32'(illegal), 32'd0);
        compare_value("reg_wen", 32'(reg_wen), 32'd0);
        compare_value("mem_wr", 32'(mem_wr), 32'd0);
        compare_value("pc_sel", 32'(pc_sel), 32'd0);
    endtask

    task automatic check_result(input case_t c);
        compare_value("out_valid", 32'(out_valid), 32'(c.valid));
        compare_value("illegal", 32'(illegal), 32'(c.illegal));
        compare_value("reg_wen", 32'(reg_wen), 32'(c.reg_wen));
        compare_value("mem_wr", 32'(mem_wr), 32'(c.mem_wr));
        compare_value("pc_sel", 32'(pc_sel), 32'(c.pc_sel));
        // Selects are don't care for bubbles and illegal encodings
        if (c.valid && !c.illegal) begin
            compare_value("a_sel", 32'(a_sel), 32'(c.a_sel));
            compare_value("b_sel", 32'(b_sel), 32'(c.b_sel));
            compare_value("alu_sel", 32'(alu_sel), 32'(c.alu_sel));
            compare_value("imm_sel", 32'(imm_sel), 32'(c.imm_sel));
            compare_value("wb_sel", 32'(wb_sel), 32'(c.wb_sel));
        end
    endtask

    initial begin
        case_t       c;
        logic [31:0] word;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        instruction = '0;
        br_eq       = 1'b0;
        br_lt       = 1'b0;
        lfsr        = LFSR_SEED;
        cycles      = 0;
        read_cases();
        limit = cases.size() + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        foreach (cases[i]) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (pending.size() == 0) begin
                expect_idle();
            end else begin
                check_result(pending.pop_front());
            end
            c = cases[i];
            scramble_fields(c.instr, word);
            in_valid    = c.valid;
            instruction = word;
            br_eq       = c.br_eq;
            br_lt       = c.br_lt;
            pending.push_back(c);
            // br_un feeds the comparator in the same cycle
            #COMB_DELAY;
            compare_value("br_un", 32'(br_un), 32'(c.br_un));
        end
        @(posedge clk);
        #DRIVE_DELAY;
        check_result(pending.pop_front());
        in_valid = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        expect_idle();
        if (DUT.u_asserts.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("%0d assertion failures during the run", DUT.u_asserts.fail_count);
            $display("=== FAIL ===");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* verification/instr_ctl_cases.txt */
# valid instruction br_eq br_lt, expected: illegal a_sel b_sel alu_sel imm_sel reg_wen mem_wr
# wb_sel br_un pc_sel; all hex, alu_sel imm_sel wb_sel in rv_ctl_pkg codes, selects x if illegal
1 00000037 0 0  0 0 1 5 4 1 0 1 0 0  # lui
1 00000017 1 1  0 1 1 2 4 1 0 1 0 0  # auipc
1 0000006f 0 0  0 1 1 2 5 1 0 2 0 1  # jal
0 0000006f 1 1  0 0 0 0 0 0 0 0 0 0  # jal with in_valid low
1 0000006f 1 1  0 1 1 2 5 1 0 2 0 1  # jal
1 00000067 1 0  0 0 1 2 1 1 0 2 0 1  # jalr
1 00000067 0 1  0 0 1 2 1 1 0 2 0 1  # jalr
1 00000063 0 0  0 1 1 2 3 0 0 1 0 0  # beq
1 00000063 0 1  0 1 1 2 3 0 0 1 0 0  # beq
1 00000063 1 0  0 1 1 2 3 0 0 1 0 1  # beq
1 00000063 1 1  0 1 1 2 3 0 0 1 0 1  # beq
1 00001063 0 0  0 1 1 2 3 0 0 1 0 1  # bne
1 00001063 0 1  0 1 1 2 3 0 0 1 0 1  # bne
1 00001063 1 0  0 1 1 2 3 0 0 1 0 0  # bne
1 00001063 1 1  0 1 1 2 3 0 0 1 0 0  # bne
1 00004063 0 0  0 1 1 2 3 0 0 1 0 0  # blt
1 00004063 0 1  0 1 1 2 3 0 0 1 0 1  # blt
1 00004063 1 0  0 1 1 2 3 0 0 1 0 0  # blt
1 00004063 1 1  0 1 1 2 3 0 0 1 0 1  # blt
1 00005063 0 0  0 1 1 2 3 0 0 1 0 1  # bge
1 00005063 0 1  0 1 1 2 3 0 0 1 0 0  # bge
1 00005063 1 0  0 1 1 2 3 0 0 1 0 1  # bge
1 00005063 1 1  0 1 1 2 3 0 0 1 0 0  # bge
1 00006063 0 0  0 1 1 2 3 0 0 1 1 0  # bltu
1 00006063 0 1  0 1 1 2 3 0 0 1 1 1  # bltu
1 00006063 1 0  0 1 1 2 3 0 0 1 1 0  # bltu
1 00006063 1 1  0 1 1 2 3 0 0 1 1 1  # bltu
1 00007063 0 0  0 1 1 2 3 0 0 1 1 1  # bgeu
1 00007063 0 1  0 1 1 2 3 0 0 1 1 0  # bgeu
1 00007063 1 0  0 1 1 2 3 0 0 1 1 1  # bgeu
1 00007063 1 1  0 1 1 2 3 0 0 1 1 0  # bgeu
1 00000003 1 0  0 0 1 2 1 1 0 0 0 0  # lb
1 00001003 0 1  0 0 1 2 1 1 0 0 0 0  # lh
1 00002003 1 1  0 0 1 2 1 1 0 0 0 0  # lw
1 00004003 0 0  0 0 1 2 1 1 0 0 0 0  # lbu
1 00005003 0 0  0 0 1 2 1 1 0 0 0 0  # lhu
1 00000023 1 1  0 0 1 2 2 0 1 1 0 0  # sb
0 00000023 1 1  0 0 0 0 0 0 0 0 0 0  # sb with in_valid low
1 00001023 0 0  0 0 1 2 2 0 1 1 0 0  # sh
1 00002023 1 0  0 0 1 2 2 0 1 1 0 0  # sw
1 00000013 0 0  0 0 1 2 1 1 0 1 0 0  # addi
1 00002013 0 0  0 0 1 4 1 1 0 1 0 0  # slti
1 00003013 0 0  0 0 1 6 1 1 0 1 0 0  # sltiu
1 00004013 0 0  0 0 1 9 1 1 0 1 0 0  # xori
1 00006013 0 0  0 0 1 1 1 1 0 1 0 0  # ori
1 00007013 0 0  0 0 1 0 1 1 0 1 0 0  # andi
1 00001013 0 0  0 0 1 8 1 1 0 1 0 0  # slli
1 00005013 0 0  0 0 1 c 1 1 0 1 0 0  # srli
1 40005013 0 0  0 0 1 d 1 1 0 1 0 0  # srai
1 00000033 0 1  0 0 0 2 0 1 0 1 0 0  # add
1 40000033 0 1  0 0 0 3 0 1 0 1 0 0  # sub
1 00001033 0 1  0 0 0 8 0 1 0 1 0 0  # sll
1 00002033 0 1  0 0 0 4 0 1 0 1 0 0  # slt
1 00003033 0 1  0 0 0 6 0 1 0 1 0 0  # sltu
1 00004033 0 1  0 0 0 9 0 1 0 1 0 0  # xor
1 00005033 0 1  0 0 0 c 0 1 0 1 0 0  # srl
1 40005033 0 1  0 0 0 d 0 1 0 1 0 0  # sra
1 00006033 0 1  0 0 0 1 0 1 0 1 0 0  # or
1 00007033 0 1  0 0 0 0 0 1 0 1 0 0  # and
1 0000000f 1 0  1 0 0 0 0 0 0 0 0 0  # fence opcode
1 00000073 1 0  1 0 0 0 0 0 0 0 0 0  # system opcode
1 00002063 1 0  1 0 0 0 0 0 0 0 0 0  # branch funct3 010
1 00003063 0 1  1 0 0 0 0 0 0 0 0 0  # branch funct3 011
1 00003003 1 0  1 0 0 0 0 0 0 0 0 0  # load funct3 011
1 00006003 1 0  1 0 0 0 0 0 0 0 0 0  # load funct3 110
1 00003023 1 0  1 0 0 0 0 0 0 0 0 0  # store funct3 011
1 02000033 1 0  1 0 0 0 0 0 0 0 0 0  # op funct7 0000001
1 40001033 1 0  1 0 0 0 0 0 0 0 0 0  # op sll with funct7 0100000
1 40001013 1 0  1 0 0 0 0 0 0 0 0 0  # slli with funct7 0100000
1 00001067 1 1  1 0 0 0 0 0 0 0 0 0  # jalr funct3 001

/* instr_ctl.f */
design/rv_ctl_pkg.sv
design/main_decoder.sv
design/alu_op_decoder.sv
design/branch_resolver.sv
design/instr_ctl.sv
verification/instr_ctl_asserts.sv
verification/instr_ctl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the instr_ctl testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module instr_ctl_tb \
    --Mdir "$BUILD_DIR" \
    -f instr_ctl.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench reports them
"./$BUILD_DIR/Vinstr_ctl_tb" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi
